/* bench/ringCases.txt */
# kind chan(0 req,1 rsp) requestor opcode address data | exp: valid requestor opcode address data
# INJ QUEUE FULL: requestor column is the thread id; EJECT on rsp expects the thread id there
FWD     0 0c5 0 31002000 11111111  1 0c5 0 31002000 11111111
FWD     0 2b3 1 77000040 deadbeef  1 2b3 1 77000040 deadbeef
FWD     1 0c6 2 31000010 0000a5a5  1 0c6 2 31000010 0000a5a5
FWD     1 3ff 3 00000000 12345678  1 3ff 3 00000000 12345678
EJECT   0 0c5 0 5a001000 00000000  1 000 0 5a001000 00000000
EJECT   0 2b2 1 5aff0008 cafef00d  1 000 1 5aff0008 cafef00d
EJECT   1 16a 2 5a001000 0badc0de  1 002 2 5a001000 0badc0de
EJECT   1 169 3 31000000 00000077  1 001 3 31000000 00000077
INJ     0 001 0 31004000 00000000  1 169 0 31004000 00000000
INJ     0 003 1 77001234 a0a0a0a0  1 16b 1 77001234 a0a0a0a0
EJECT   0 0c5 0 5a002000 00000000  1 000 0 5a002000 00000000
INJ     1 000 2 5a002000 feedface  1 0c5 2 5a002000 feedface
EJECT   0 2b2 1 5a003000 00000042  1 000 1 5a003000 00000042
INJ     1 000 3 5a003000 00000000  1 2b2 3 5a003000 00000000
BUSY    0 0c4 0 31008000 00000000  0 000 0 00000000 00000000
QUEUE   0 000 0 30000000 00000001  0 000 0 00000000 00000000
QUEUE   0 001 1 30000004 00000002  0 000 0 00000000 00000000
QUEUE   0 002 0 30000008 00000003  0 000 0 00000000 00000000
QUEUE   0 003 1 3000000c 00000004  0 000 0 00000000 00000000
FULL    0 000 1 30000010 00000005  0 000 0 00000000 00000000
RELEASE 0 0c4 0 31008000 00000000  0 000 0 00000000 00000000
OUT     0 000 0 00000000 00000000  1 168 0 30000000 00000001
OUT     0 000 0 00000000 00000000  1 169 1 30000004 00000002
OUT     0 000 0 00000000 00000000  1 16a 0 30000008 00000003
OUT     0 000 0 00000000 00000000  0 000 0 00000000 00000000
OUT     0 000 0 00000000 00000000  1 16b 1 3000000c 00000004
OUT     0 000 0 00000000 00000000  1 168 1 30000010 00000005
OUT     0 000 0 00000000 00000000  0 000 0 00000000 00000000
FWD     0 1f3 1 40000000 55aa55aa  1 1f3 1 40000000 55aa55aa

/* bench/ringCtrlTb.sv */
/*
 * ring controller testbench with clock, reset, case-file stimulus,
 * four-phase core driver, output checks and watchdog
 */
`timescale 1ns/1ns

module ringCtrlTb
    import ringPkg::*;
();

    localparam int MaxRec   = 64;
    localparam int FullHold = 6;       // cycles ack must stay low on a full queue
    localparam logic [CoreIdW-1:0] CoreId = 8'h5a;

    logic               QClk;
    logic               rstN;
    logic [CoreIdW-1:0] coreId;
    logic               ringReqInValid, ringRspInValid;
    logic [ReqW-1:0]    ringReqInRequestor, ringRspInRequestor;
    opcodeT             ringReqInOpcode, ringRspInOpcode;
    logic [AddrW-1:0]   ringReqInAddress, ringRspInAddress;
    logic [AddrW-1:0]   ringReqInData, ringRspInData;
    logic               ringReqOutValid, ringRspOutValid;
    logic [ReqW-1:0]    ringReqOutRequestor, ringRspOutRequestor;
    opcodeT             ringReqOutOpcode, ringRspOutOpcode;
    logic [AddrW-1:0]   ringReqOutAddress, ringRspOutAddress;
    logic [AddrW-1:0]   ringReqOutData, ringRspOutData;
    logic               c2fReq, c2fAck, c2fRspValid, f2cReqValid, f2cRspReq, f2cRspAck;
    opcodeT             c2fOpcode, c2fRspOpcode, f2cReqOpcode, f2cRspOpcode;
    logic [AddrW-1:0]   c2fAddress, c2fData, c2fRspData;
    logic [AddrW-1:0]   f2cReqAddress, f2cReqData, f2cRspAddress, f2cRspData;
    logic [ThreadW-1:0] c2fThreadId, c2fRspThreadId;

    // per record chan req op addr data and then expected valid req op addr data
    string       kindArr [MaxRec];
    logic [31:0] recF    [MaxRec][10];
    int          nRec;
    bit          loaded;
    bit          pendReq;              // core req parked on a full queue
    int          pendIdx;

    ringCtrlTop #(.QueueDepth(4)) i_ringCtrlTop (.*);

    always #4 QClk = ~QClk;            // 8 ns period

    // ==================================================
    // reporting and checks
    // ==================================================
    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic checkField(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp)
        else stopRun($sformatf("Fail at %0t ns: %s expected %h, got %h",
                               $time, name, exp, act));
    endtask

    function automatic logic ackOf(input int chan);
        return (chan == 0) ? c2fAck : f2cRspAck;
    endfunction

    function automatic string ackName(input int chan);
        return (chan == 0) ? "c2fAck" : "f2cRspAck";
    endfunction

    function automatic logic outValidOf(input int chan);
        return (chan == 0) ? ringReqOutValid : ringRspOutValid;
    endfunction

    // ring out of the record's channel against expected columns
    task automatic checkRingOut(input int idx);
        if (recF[idx][0] == 0) begin
            checkField("ringReqOutValid", recF[idx][5], ringReqOutValid);
            checkField("ringReqOutRequestor", recF[idx][6], ringReqOutRequestor);
            checkField("ringReqOutOpcode", recF[idx][7], ringReqOutOpcode);
            checkField("ringReqOutAddress", recF[idx][8], ringReqOutAddress);
            checkField("ringReqOutData", recF[idx][9], ringReqOutData);
        end else begin
            checkField("ringRspOutValid", recF[idx][5], ringRspOutValid);
            checkField("ringRspOutRequestor", recF[idx][6], ringRspOutRequestor);
            checkField("ringRspOutOpcode", recF[idx][7], ringRspOutOpcode);
            checkField("ringRspOutAddress", recF[idx][8], ringRspOutAddress);
            checkField("ringRspOutData", recF[idx][9], ringRspOutData);
        end
    endtask

    // ==================================================
    // drivers called on the falling edge
    // ==================================================
    task automatic setRingIn(input int idx, input logic valid);
        if (recF[idx][0] == 0) begin
            ringReqInValid     = valid;
            ringReqInRequestor = recF[idx][1][ReqW-1:0];
            ringReqInOpcode    = opcodeT'(recF[idx][2][1:0]);
            ringReqInAddress   = recF[idx][3];
            ringReqInData      = recF[idx][4];
        end else begin
            ringRspInValid     = valid;
            ringRspInRequestor = recF[idx][1][ReqW-1:0];
            ringRspInOpcode    = opcodeT'(recF[idx][2][1:0]);
            ringRspInAddress   = recF[idx][3];
            ringRspInData      = recF[idx][4];
        end
    endtask

    // requestor column carries the thread id here
    task automatic coreReq(input int idx, input logic reqBit);
        if (recF[idx][0] == 0) begin
            c2fReq      = reqBit;
            c2fOpcode   = opcodeT'(recF[idx][2][1:0]);
            c2fAddress  = recF[idx][3];
            c2fData     = recF[idx][4];
            c2fThreadId = recF[idx][1][ThreadW-1:0];
        end else begin
            f2cRspReq     = reqBit;
            f2cRspOpcode  = opcodeT'(recF[idx][2][1:0]);
            f2cRspAddress = recF[idx][3];
            f2cRspData    = recF[idx][4];
        end
    endtask

    // one slot in and its result two cycles later
    task automatic ringSlot(input int idx, input bit isEject);
        @(negedge QClk);
        setRingIn(idx, 1'b1);
        @(negedge QClk);
        setRingIn(idx, 1'b0);
        @(negedge QClk);
        if (!isEject) begin
            checkRingOut(idx);
            checkField("f2cReqValid", 0, f2cReqValid);
            checkField("c2fRspValid", 0, c2fRspValid);
        end else if (recF[idx][0] == 0) begin
            checkField("f2cReqValid", recF[idx][5], f2cReqValid);
            checkField("f2cReqOpcode", recF[idx][7], f2cReqOpcode);
            checkField("f2cReqAddress", recF[idx][8], f2cReqAddress);
            checkField("f2cReqData", recF[idx][9], f2cReqData);
            checkField("ringReqOutValid", 0, ringReqOutValid);   // not forwarded
        end else begin
            checkField("c2fRspValid", recF[idx][5], c2fRspValid);
            checkField("c2fRspThreadId", recF[idx][6], c2fRspThreadId);
            checkField("c2fRspOpcode", recF[idx][7], c2fRspOpcode);
            checkField("c2fRspData", recF[idx][9], c2fRspData);
            checkField("ringRspOutValid", 0, ringRspOutValid);
        end
    endtask

    // full four-phase cycle on a queue with room
    task automatic coreHandshake(input int idx);
        int chan;
        chan = recF[idx][0];
        @(negedge QClk);
        coreReq(idx, 1'b1);
        @(negedge QClk);
        checkField(ackName(chan), 1, ackOf(chan));   // ack one cycle after req
        coreReq(idx, 1'b0);
        @(negedge QClk);
        checkField(ackName(chan), 0, ackOf(chan));   // ack follows req down
    endtask

    task automatic injectAndCheck(input int idx);
        int chan;
        int waited;
        chan   = recF[idx][0];
        waited = 0;
        coreHandshake(idx);
        while (!outValidOf(chan) && waited < 16) begin
            @(negedge QClk);
            waited++;
        end
        assert (outValidOf(chan))
        else stopRun("injected core message never reached the ring output");
        checkRingOut(idx);
    endtask

    // req raised into a full queue gets no ack
    task automatic raiseWhileFull(input int idx);
        @(negedge QClk);
        coreReq(idx, 1'b1);
        repeat (FullHold) begin
            @(negedge QClk);
            checkField(ackName(recF[idx][0]), 0, ackOf(recF[idx][0]));
        end
        pendIdx = idx;
        pendReq = 1'b1;
    endtask

    task automatic finishPending(input int idx);
        int chan;
        int waited;
        chan   = recF[idx][0];
        waited = 0;
        while (!ackOf(chan) && waited < 16) begin
            @(negedge QClk);
            waited++;
        end
        assert (ackOf(chan))
        else stopRun("parked core request was never acknowledged after the ring freed up");
        coreReq(idx, 1'b0);
        @(negedge QClk);
        checkField(ackName(chan), 0, ackOf(chan));
        pendReq = 1'b0;
    endtask

    // drop the busy slot while the parked req completes
    task automatic releaseRing(input int idx);
        @(negedge QClk);
        setRingIn(idx, 1'b0);
        if (pendReq) begin
            fork
                finishPending(pendIdx);
            join_none
        end
        @(negedge QClk);
    endtask

    // ==================================================
    // watchdog
    // ==================================================
    initial begin
        wait (loaded);
        repeat (nRec * 40 + 200) @(posedge QClk);
        stopRun("watchdog expired before the case list finished");
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int          fd;
        int          rc;
        string       lineStr;
        string       k;
        logic [31:0] v [10];
        QClk = 1'b0;
        rstN = 1'b0;
        coreId = CoreId;
        ringReqInValid = 1'b0;
        ringReqInRequestor = '0;
        ringReqInOpcode = opRd;
        ringReqInAddress = '0;
        ringReqInData = '0;
        ringRspInValid = 1'b0;
        ringRspInRequestor = '0;
        ringRspInOpcode = opRd;
        ringRspInAddress = '0;
        ringRspInData = '0;
        c2fReq = 1'b0;
        c2fOpcode = opRd;
        c2fAddress = '0;
        c2fData = '0;
        c2fThreadId = '0;
        f2cRspReq = 1'b0;
        f2cRspOpcode = opRd;
        f2cRspAddress = '0;
        f2cRspData = '0;
        pendReq = 1'b0;
        loaded = 1'b0;
        nRec = 0;
        void'($urandom(32'h92e4_7135));   // only idle gaps are random
        fd = $fopen("bench/ringCases.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the case file bench/ringCases.txt");
        end else begin
            while (!$feof(fd) && nRec < MaxRec) begin
                rc = $fgets(lineStr, fd);
                if (rc != 0) begin
                    rc = $sscanf(lineStr, "%s %h %h %h %h %h %h %h %h %h %h", k,
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (rc == 11) begin        // comment lines fall out here
                        kindArr[nRec] = k;
                        for (int j = 0; j < 10; j++) recF[nRec][j] = v[j];
                        nRec++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (2) @(negedge QClk);
        rstN = 1'b1;
        @(negedge QClk);
        checkField("ringReqOutValid", 0, ringReqOutValid);
        checkField("ringRspOutValid", 0, ringRspOutValid);
        checkField("f2cReqValid", 0, f2cReqValid);
        checkField("c2fRspValid", 0, c2fRspValid);
        checkField("c2fAck", 0, c2fAck);
        checkField("f2cRspAck", 0, f2cRspAck);

        for (int i = 0; i < nRec; i++) begin
            // gaps only where cycle alignment between records does not matter
            if (kindArr[i] == "FWD" || kindArr[i] == "EJECT" || kindArr[i] == "INJ")
                repeat ($urandom % 3) @(negedge QClk);
            if (kindArr[i] == "FWD") ringSlot(i, 1'b0);
            else if (kindArr[i] == "EJECT") ringSlot(i, 1'b1);
            else if (kindArr[i] == "INJ") injectAndCheck(i);
            else if (kindArr[i] == "QUEUE") coreHandshake(i);
            else if (kindArr[i] == "FULL") raiseWhileFull(i);
            else if (kindArr[i] == "RELEASE") releaseRing(i);
            else if (kindArr[i] == "OUT") begin
                @(negedge QClk);
                checkRingOut(i);
            end else if (kindArr[i] == "BUSY") begin
                @(negedge QClk);
                setRingIn(i, 1'b1);            // held until RELEASE
            end else stopRun({"unknown case kind in case file: ", kindArr[i]});
        end

        repeat (4) @(negedge QClk);
        $display("Regression passed");
        $finish;
    end

endmodule

/* flist.f */
hw/ringPkg.sv
hw/ringMsgIf.sv
hw/ringChannel.sv
hw/injectQueue.sv
hw/ejectPort.sv
hw/ringCtrlTop.sv
bench/ringCtrlTb.sv

/* hw/ejectPort.sv */
/*
 * eject port: registers owned ring messages onto core outputs
 */
`timescale 1ns/1ns

module ejectPort
    import ringPkg::*;
(
    input  logic             QClk,
    input  logic             rstN,
    ringMsgIf.dst            eject,
    output logic             valid,
    output logic [ReqW-1:0]  requestor,
    output opcodeT           opcode,
    output logic [AddrW-1:0] address,
    output logic [AddrW-1:0] data
);

    // the core never stalls the ring
    assign eject.take = 1'b0;

    // one-cycle pulse per delivered message
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else begin
            valid <= eject.valid;
        end
    end

    // held between messages, requestor tags the next core response
    always_ff @(posedge QClk) begin
        if (eject.valid) begin
            requestor <= eject.requestor;
            opcode    <= eject.opcode;
            address   <= eject.address;
            data      <= eject.data;
        end
    end

endmodule

/* hw/injectQueue.sv */
/*
 * core injection queue: four-phase req/ack capture stage
 * and a small FIFO presenting its head to the channel local slot
 */
`timescale 1ns/1ns

module injectQueue
    import ringPkg::*;
#(
    parameter int Depth = 4
) (
    input  logic             QClk,
    input  logic             rstN,
    input  logic             req,
    output logic             ack,
    input  opcodeT           opcode,
    input  logic [AddrW-1:0] address,
    input  logic [AddrW-1:0] data,
    input  logic [ReqW-1:0]  requestor,
    ringMsgIf.src            localSlot
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    // FIFO storage
    logic [ReqW-1:0]  memRequestor [Depth];
    opcodeT           memOpcode    [Depth];
    logic [AddrW-1:0] memAddress   [Depth];
    logic [AddrW-1:0] memData      [Depth];

    // capture stage between handshake and FIFO
    logic             holdValid;
    logic [ReqW-1:0]  holdRequestor;
    opcodeT           holdOpcode;
    logic [AddrW-1:0] holdAddress;
    logic [AddrW-1:0] holdData;

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            full;
    logic            accept;
    logic            pop;

    function automatic logic [PtrW-1:0] incPtr(input logic [PtrW-1:0] p);
        return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1; // wraps for any depth
    endfunction

    assign full   = (count == CntW'(Depth));
    assign accept = req && !ack && !full;   // new req only after ack fell
    assign pop    = localSlot.take && localSlot.valid;

    // ==================================================
    // four-phase handshake
    // ==================================================
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            ack       <= 1'b0;
            holdValid <= 1'b0;
        end else begin
            holdValid <= accept;    // one-cycle pulse, pushes next edge
            if (accept) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;        // core let go, close handshake
            end
        end
    end

    always_ff @(posedge QClk) begin
        if (accept) begin
            holdRequestor <= requestor;
            holdOpcode    <= opcode;
            holdAddress   <= address;
            holdData      <= data;
        end
    end

    // ==================================================
    // FIFO
    // ==================================================
    always_ff @(posedge QClk) begin
        if (holdValid) begin
            memRequestor[wrPtr] <= holdRequestor;
            memOpcode[wrPtr]    <= holdOpcode;
            memAddress[wrPtr]   <= holdAddress;
            memData[wrPtr]      <= holdData;
        end
    end

    // room is guaranteed, accept saw !full and only pops happen meanwhile
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (holdValid) wrPtr <= incPtr(wrPtr);
            if (pop)       rdPtr <= incPtr(rdPtr);
            case ({holdValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    // head entry to the channel
    assign localSlot.valid     = (count != '0);
    assign localSlot.requestor = memRequestor[rdPtr];
    assign localSlot.opcode    = memOpcode[rdPtr];
    assign localSlot.address   = memAddress[rdPtr];
    assign localSlot.data      = memData[rdPtr];

endmodule

/* hw/ringChannel.sv */
/*
 * one ring channel with input slot register, ownership match,
 * ventilation counter, output-slot select and output register
 */
`timescale 1ns/1ns

module ringChannel
    import ringPkg::*;
#(
    parameter bit MatchOnAddress = 1'b1 // 1 = request channel, 0 = response channel
) (
    input  logic             QClk,
    input  logic             rstN,
    input  logic [CoreIdW-1:0] coreId,
    // ring slot in
    input  logic             inValid,
    input  logic [ReqW-1:0]  inRequestor,
    input  opcodeT           inOpcode,
    input  logic [AddrW-1:0] inAddress,
    input  logic [AddrW-1:0] inData,
    // ring slot out
    output logic             outValid,
    output logic [ReqW-1:0]  outRequestor,
    output opcodeT           outOpcode,
    output logic [AddrW-1:0] outAddress,
    output logic [AddrW-1:0] outData,
    // core side
    ringMsgIf.dst            localSlot,  // queued message waiting to inject
    ringMsgIf.src            eject       // owned message going to the core
);

    // ==================================================
    // registered ring input
    // ==================================================
    logic             inValidQ;
    logic [ReqW-1:0]  inRequestorQ;
    opcodeT           inOpcodeQ;
    logic [AddrW-1:0] inAddressQ;
    logic [AddrW-1:0] inDataQ;

    logic                ownMatch;    // slot belongs to this core
    logic                mustFwd;     // valid foreign slot, forward it
    logic                needVent;    // ventilation limit hit
    logic [VentCntW-1:0] ventCnt;
    selT                 sel;

    logic             nextValid;
    logic [ReqW-1:0]  nextRequestor;
    opcodeT           nextOpcode;
    logic [AddrW-1:0] nextAddress;
    logic [AddrW-1:0] nextData;

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            inValidQ <= 1'b0;
        end else begin
            inValidQ <= inValid;
        end
    end

    // payload registers follow the ring slot
    always_ff @(posedge QClk) begin
        inRequestorQ <= inRequestor;
        inOpcodeQ    <= inOpcode;
        inAddressQ   <= inAddress;
        inDataQ      <= inData;
    end

    // ==================================================
    // ownership and slot select
    // ==================================================
    // requests match on address top byte, responses on requestor core id
    assign ownMatch = MatchOnAddress ? (inAddressQ[AddrW-1 -: CoreIdW] == coreId)
                                     : (inRequestorQ[ReqW-1 -: CoreIdW] == coreId);
    assign mustFwd  = inValidQ && !ownMatch;
    assign needVent = (ventCnt == VentCntW'(VentLimit));

    // forward > ventilate > local > bubble
    always_comb begin
        casez ({mustFwd, needVent, localSlot.valid})
            3'b1??:  sel = selRing;
            3'b01?:  sel = selBubble;  // forced ventilation slot
            3'b001:  sel = selLocal;
            default: sel = selBubble;  // nothing to send
        endcase
    end

    // counts back-to-back injections
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            ventCnt <= '0;
        end else if (sel == selBubble) begin
            ventCnt <= '0;                  // ring got a free slot
        end else if (sel == selLocal) begin
            ventCnt <= ventCnt + 1'b1;
        end
    end

    assign localSlot.take = (sel == selLocal); // queue pops on this edge

    // ==================================================
    // output mux and register
    // ==================================================
    always_comb begin
        nextValid     = 1'b0;             // bubble by default
        nextRequestor = '0;
        nextOpcode    = opRd;
        nextAddress   = '0;
        nextData      = '0;
        case (sel)
            selRing: begin
                nextValid     = inValidQ;
                nextRequestor = inRequestorQ;
                nextOpcode    = inOpcodeQ;
                nextAddress   = inAddressQ;
                nextData      = inDataQ;
            end
            selLocal: begin
                nextValid     = localSlot.valid;
                nextRequestor = localSlot.requestor;
                nextOpcode    = localSlot.opcode;
                nextAddress   = localSlot.address;
                nextData      = localSlot.data;
            end
            default: ;
        endcase
    end

    always_ff @(posedge QClk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= nextValid;
        end
    end

    always_ff @(posedge QClk) begin
        outRequestor <= nextRequestor;
        outOpcode    <= nextOpcode;
        outAddress   <= nextAddress;
        outData      <= nextData;
    end

    // owned slot leaves to the core in the decision cycle
    assign eject.valid     = inValidQ && ownMatch;
    assign eject.requestor = inRequestorQ;
    assign eject.opcode    = inOpcodeQ;
    assign eject.address   = inAddressQ;
    assign eject.data      = inDataQ;

endmodule

/* hw/ringCtrlTop.sv */
/*
 * ring controller top: request and response channels,
 * core injection queues and eject ports
 */
`timescale 1ns/1ns

module ringCtrlTop
    import ringPkg::*;
#(
    parameter int QueueDepth = 4    // entries per injection queue
) (
    input  logic               QClk,
    input  logic               rstN,
    input  logic [CoreIdW-1:0] coreId,
    // ==================================================
    // ring side
    // ==================================================
    input  logic               ringReqInValid,
    input  logic [ReqW-1:0]    ringReqInRequestor,
    input  opcodeT             ringReqInOpcode,
    input  logic [AddrW-1:0]   ringReqInAddress,
    input  logic [AddrW-1:0]   ringReqInData,
    input  logic               ringRspInValid,
    input  logic [ReqW-1:0]    ringRspInRequestor,
    input  opcodeT             ringRspInOpcode,
    input  logic [AddrW-1:0]   ringRspInAddress,
    input  logic [AddrW-1:0]   ringRspInData,
    output logic               ringReqOutValid,
    output logic [ReqW-1:0]    ringReqOutRequestor,
    output opcodeT             ringReqOutOpcode,
    output logic [AddrW-1:0]   ringReqOutAddress,
    output logic [AddrW-1:0]   ringReqOutData,
    output logic               ringRspOutValid,
    output logic [ReqW-1:0]    ringRspOutRequestor,
    output opcodeT             ringRspOutOpcode,
    output logic [AddrW-1:0]   ringRspOutAddress,
    output logic [AddrW-1:0]   ringRspOutData,
    // ==================================================
    // core side
    // ==================================================
    input  logic               c2fReq,          // core request, four-phase
    output logic               c2fAck,
    input  opcodeT             c2fOpcode,
    input  logic [AddrW-1:0]   c2fAddress,
    input  logic [AddrW-1:0]   c2fData,
    input  logic [ThreadW-1:0] c2fThreadId,
    output logic               c2fRspValid,     // responses back to the core
    output opcodeT             c2fRspOpcode,
    output logic [AddrW-1:0]   c2fRspData,
    output logic [ThreadW-1:0] c2fRspThreadId,
    output logic               f2cReqValid,     // ring requests for the core
    output opcodeT             f2cReqOpcode,
    output logic [AddrW-1:0]   f2cReqAddress,
    output logic [AddrW-1:0]   f2cReqData,
    input  logic               f2cRspReq,       // core response, four-phase
    output logic               f2cRspAck,
    input  opcodeT             f2cRspOpcode,
    input  logic [AddrW-1:0]   f2cRspAddress,
    input  logic [AddrW-1:0]   f2cRspData
);

    ringMsgIf reqLocalIf ();    // reqQueue -> reqChannel
    ringMsgIf rspLocalIf ();    // rspQueue -> rspChannel
    ringMsgIf reqEjectIf ();    // reqChannel -> f2cEject
    ringMsgIf rspEjectIf ();    // rspChannel -> c2fEject

    logic [ReqW-1:0] f2cHeldRequestor;  // requestor of last request given to core
    logic [ReqW-1:0] c2fRspRequestor;

    assign c2fRspThreadId = c2fRspRequestor[ThreadW-1:0];

    // ==================================================
    // request channel
    // ==================================================
    injectQueue #(.Depth(QueueDepth)) reqQueue (
        .QClk      (QClk),
        .rstN      (rstN),
        .req       (c2fReq),
        .ack       (c2fAck),
        .opcode    (c2fOpcode),
        .address   (c2fAddress),
        .data      (c2fData),
        .requestor ({coreId, c2fThreadId}),
        .localSlot (reqLocalIf.src)
    );

    ringChannel #(.MatchOnAddress(1'b1)) reqChannel (
        .QClk         (QClk),
        .rstN         (rstN),
        .coreId       (coreId),
        .inValid      (ringReqInValid),
        .inRequestor  (ringReqInRequestor),
        .inOpcode     (ringReqInOpcode),
        .inAddress    (ringReqInAddress),
        .inData       (ringReqInData),
        .outValid     (ringReqOutValid),
        .outRequestor (ringReqOutRequestor),
        .outOpcode    (ringReqOutOpcode),
        .outAddress   (ringReqOutAddress),
        .outData      (ringReqOutData),
        .localSlot    (reqLocalIf.dst),
        .eject        (reqEjectIf.src)
    );

    ejectPort f2cEject (
        .QClk      (QClk),
        .rstN      (rstN),
        .eject     (reqEjectIf.dst),
        .valid     (f2cReqValid),
        .requestor (f2cHeldRequestor),
        .opcode    (f2cReqOpcode),
        .address   (f2cReqAddress),
        .data      (f2cReqData)
    );

    // ==================================================
    // response channel
    // ==================================================
    injectQueue #(.Depth(QueueDepth)) rspQueue (
        .QClk      (QClk),
        .rstN      (rstN),
        .req       (f2cRspReq),
        .ack       (f2cRspAck),
        .opcode    (f2cRspOpcode),
        .address   (f2cRspAddress),
        .data      (f2cRspData),
        .requestor (f2cHeldRequestor),   // answer goes back to the asker
        .localSlot (rspLocalIf.src)
    );

    ringChannel #(.MatchOnAddress(1'b0)) rspChannel (
        .QClk         (QClk),
        .rstN         (rstN),
        .coreId       (coreId),
        .inValid      (ringRspInValid),
        .inRequestor  (ringRspInRequestor),
        .inOpcode     (ringRspInOpcode),
        .inAddress    (ringRspInAddress),
        .inData       (ringRspInData),
        .outValid     (ringRspOutValid),
        .outRequestor (ringRspOutRequestor),
        .outOpcode    (ringRspOutOpcode),
        .outAddress   (ringRspOutAddress),
        .outData      (ringRspOutData),
        .localSlot    (rspLocalIf.dst),
        .eject        (rspEjectIf.src)
    );

    // core has no use for the response address
    ejectPort c2fEject (
        .QClk      (QClk),
        .rstN      (rstN),
        .eject     (rspEjectIf.dst),
        .valid     (c2fRspValid),
        .requestor (c2fRspRequestor),
        .opcode    (c2fRspOpcode),
        .address   (),
        .data      (c2fRspData)
    );

endmodule

/* hw/ringMsgIf.sv */
/*
 * one ring message plus its take strobe
 * src drives the message, dst answers with take
 */
`timescale 1ns/1ns

interface ringMsgIf
    import ringPkg::*;
();
    logic             valid;
    logic [ReqW-1:0]  requestor;   // {coreId, threadId}
    opcodeT           opcode;
    logic [AddrW-1:0] address;
    logic [AddrW-1:0] data;
    logic             take;        // consumer takes the message this cycle

    // producer side
    modport src (
        output valid, requestor, opcode, address, data,
        input  take
    );

    // consumer side
    modport dst (
        input  valid, requestor, opcode, address, data,
        output take
    );

endinterface

/* hw/ringPkg.sv */
/*
 * shared ring controller definitions
 * message widths, opcode and output-slot enums, ventilation limit
 */
package ringPkg;

    // ==================================================
    // message field widths
    // ==================================================
    localparam int AddrW   = 32;               // address and data
    localparam int CoreIdW = 8;                // core id, also address top byte
    localparam int ThreadW = 2;                // thread id inside a core
    localparam int ReqW    = CoreIdW + ThreadW; // requestor = {coreId, threadId}

    // ==================================================
    // ventilation
    // ==================================================
    // consecutive local injections before a forced bubble
    localparam int VentLimit = 3;
    localparam int VentCntW  = $clog2(VentLimit + 1); // counter must reach VentLimit

    // ==================================================
    // enums
    // ==================================================
    // ring opcodes, opRd doubles as the bubble opcode
    typedef enum logic [1:0] {
        opRd    = 2'b00,
        opWr    = 2'b01,
        opRdRsp = 2'b10,
        opWrRsp = 2'b11
    } opcodeT;

    // who owns the output slot this cycle
    typedef enum logic [1:0] {
        selBubble = 2'b00,   // empty slot
        selRing   = 2'b01,   // forward ring input
        selLocal  = 2'b10    // inject from local queue
    } selT;

endpackage
